// ==== sfp_mgmt_pkg.sv ====
// Shared design types for the SFP management block, referenced by scoped name
package sfp_mgmt_pkg;

    // I2C transfer fields
    typedef logic [6:0] i2c_dev_addr_t;
    typedef logic [7:0] i2c_reg_addr_t;
    typedef logic [7:0] i2c_data_t;

    // Bit-level states of the random-read master
    typedef enum logic [3:0] {
        I2C_IDLE,
        I2C_START,
        I2C_ADDR,
        I2C_REG,
        I2C_RESTART,
        I2C_READ,
        I2C_ACK,
        I2C_STOP,
        I2C_DONE
    } i2c_state_t;

    // Request states of the two bus peers
    typedef enum logic [1:0] {
        POLL_IDLE,
        POLL_REQ,
        POLL_WAIT
    } poll_state_t;

endpackage

// ==== sfp_map_pkg.sv ====
// SFP two-wire memory map constants used by the identifier and diagnostics readers
package sfp_map_pkg;

    // Serial ID EEPROM, A0h in 8-bit notation
    localparam logic [6:0] SFP_ID_DEV_ADDR = 7'h50;
    // Identifier byte, module type code
    localparam logic [7:0] SFP_ID_REG = 8'd0;

    // Digital diagnostics page, A2h in 8-bit notation
    localparam logic [6:0] SFP_DIAG_DEV_ADDR = 7'h51;
    // Temperature MSB, whole degrees C
    localparam logic [7:0] SFP_TEMP_REG = 8'd96;

endpackage

// ==== board_io_sync.sv ====
// Synchronizes SFP cage status and I2C line inputs and registers the I2C drive-low enables
module board_io_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic clk_125mhz_int,
    input  logic arst_n_i,
    input  logic sfp_tx_fault_i,
    input  logic sfp_rx_los_i,
    input  logic sfp_mod_abs_i,
    input  logic scl_pin_i,
    input  logic sda_pin_i,
    input  logic scl_drv_i,
    input  logic sda_drv_i,
    output logic tx_fault_o,
    output logic rx_los_o,
    output logic mod_abs_o,
    output logic scl_o,
    output logic sda_o,
    output logic scl_oe_o,
    output logic sda_oe_o
);

    // Idle view of the pins: no fault, loss of signal, module absent, bus released
    localparam logic [4:0] SYNC_RST = 5'b01111;

    logic [4:0] sync_q [SYNC_STAGES];

    always_ff @(posedge clk_125mhz_int or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= SYNC_RST;
            end
            scl_oe_o <= 1'b0;
            sda_oe_o <= 1'b0;
        end else begin
            sync_q[0] <= {sfp_tx_fault_i, sfp_rx_los_i, sfp_mod_abs_i, scl_pin_i, sda_pin_i};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            // Output flops keep the pad drivers glitch free
            scl_oe_o <= scl_drv_i;
            sda_oe_o <= sda_drv_i;
        end
    end

    assign {tx_fault_o, rx_los_o, mod_abs_o, scl_o, sda_o} = sync_q[SYNC_STAGES-1];

endmodule

// ==== i2c_random_reader.sv ====
// Single-byte I2C random-read master, started by a strobe and ending with a done pulse
module i2c_random_reader #(
    parameter int SCL_QUARTER = 4
) (
    input  logic                        clk_125mhz_int,
    input  logic                        arst_n_i,
    input  logic                        start_i,
    input  sfp_mgmt_pkg::i2c_dev_addr_t dev_addr_i,
    input  sfp_mgmt_pkg::i2c_reg_addr_t reg_addr_i,
    input  logic                        scl_i,
    input  logic                        sda_i,
    output logic                        scl_drv_o,
    output logic                        sda_drv_o,
    output logic                        busy_o,
    output logic                        done_o,
    output logic                        nack_o,
    output sfp_mgmt_pkg::i2c_data_t     data_o
);

    localparam logic [15:0] QMAX = 16'(SCL_QUARTER - 1);

    sfp_mgmt_pkg::i2c_state_t    state;
    sfp_mgmt_pkg::i2c_dev_addr_t dev_q;
    sfp_mgmt_pkg::i2c_reg_addr_t reg_q;
    sfp_mgmt_pkg::i2c_data_t     tx_sr;
    sfp_mgmt_pkg::i2c_data_t     rx_sr;
    logic [15:0]                 qcnt;
    logic [1:0]                  ph;
    logic [2:0]                  bit_cnt;
    logic [1:0]                  byte_idx;
    logic                        nack_q;
    logic                        step;

    // Quarter tick; the sampling quarter waits for SCL to read back high
    assign step = (qcnt == QMAX) && (scl_i || ph != 2'd2);

    always_ff @(posedge clk_125mhz_int or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state     <= sfp_mgmt_pkg::I2C_IDLE;
            qcnt      <= '0;
            ph        <= '0;
            bit_cnt   <= '0;
            byte_idx  <= '0;
            nack_q    <= 1'b0;
            scl_drv_o <= 1'b0;
            sda_drv_o <= 1'b0;
        end else if (state == sfp_mgmt_pkg::I2C_IDLE) begin
            qcnt     <= '0;
            ph       <= '0;
            bit_cnt  <= '0;
            byte_idx <= '0;
            if (start_i) begin
                nack_q <= 1'b0;
                state  <= sfp_mgmt_pkg::I2C_START;
            end
        end else if (state == sfp_mgmt_pkg::I2C_DONE) begin
            state <= sfp_mgmt_pkg::I2C_IDLE;
        end else if (!step) begin
            if (qcnt != QMAX) begin
                qcnt <= qcnt + 16'd1;
            end
        end else begin
            qcnt <= '0;
            ph   <= ph + 2'd1;
            case (state)
                sfp_mgmt_pkg::I2C_START, sfp_mgmt_pkg::I2C_RESTART: begin
                    case (ph)
                        2'd0: sda_drv_o <= 1'b0;
                        2'd1: scl_drv_o <= 1'b0;
                        // SDA falls while SCL is high
                        2'd2: sda_drv_o <= 1'b1;
                        default: begin
                            scl_drv_o <= 1'b1;
                            state     <= sfp_mgmt_pkg::I2C_ADDR;
                        end
                    endcase
                end
                sfp_mgmt_pkg::I2C_STOP: begin
                    case (ph)
                        2'd0: sda_drv_o <= 1'b1;
                        2'd1: scl_drv_o <= 1'b0;
                        2'd2: sda_drv_o <= 1'b0;
                        default: state <= sfp_mgmt_pkg::I2C_DONE;
                    endcase
                end
                default: begin
                    // Address, register, read and acknowledge bits
                    case (ph)
                        2'd0: sda_drv_o <= (state == sfp_mgmt_pkg::I2C_ADDR ||
                                            state == sfp_mgmt_pkg::I2C_REG) && !tx_sr[7];
                        2'd1: scl_drv_o <= 1'b0;
                        2'd2: begin
                            if (state == sfp_mgmt_pkg::I2C_ACK && byte_idx != 2'd3 && sda_i) begin
                                nack_q <= 1'b1;
                            end
                        end
                        default: begin
                            scl_drv_o <= 1'b1;
                            bit_cnt   <= bit_cnt + 3'd1;
                            if (state == sfp_mgmt_pkg::I2C_ACK) begin
                                bit_cnt  <= '0;
                                byte_idx <= byte_idx + 2'd1;
                                // Master NACK after the data byte, then STOP
                                if (nack_q || byte_idx == 2'd3) begin
                                    state <= sfp_mgmt_pkg::I2C_STOP;
                                end else if (byte_idx == 2'd0) begin
                                    state <= sfp_mgmt_pkg::I2C_REG;
                                end else if (byte_idx == 2'd1) begin
                                    state <= sfp_mgmt_pkg::I2C_RESTART;
                                end else begin
                                    state <= sfp_mgmt_pkg::I2C_READ;
                                end
                            end else if (bit_cnt == 3'd7) begin
                                state <= sfp_mgmt_pkg::I2C_ACK;
                            end
                        end
                    endcase
                end
            endcase
        end
    end

    // Address, shift and receive registers
    always_ff @(posedge clk_125mhz_int) begin
        if (state == sfp_mgmt_pkg::I2C_IDLE && start_i) begin
            dev_q <= dev_addr_i;
            reg_q <= reg_addr_i;
        end
        if (step && ph == 2'd3) begin
            if (state == sfp_mgmt_pkg::I2C_START || state == sfp_mgmt_pkg::I2C_RESTART) begin
                // R/W bit is 1 only after the repeated START
                tx_sr <= {dev_q, state == sfp_mgmt_pkg::I2C_RESTART};
            end else if (state == sfp_mgmt_pkg::I2C_ADDR || state == sfp_mgmt_pkg::I2C_REG) begin
                tx_sr <= (bit_cnt == 3'd7) ? reg_q : {tx_sr[6:0], 1'b0};
            end
        end
        if (step && ph == 2'd2 && state == sfp_mgmt_pkg::I2C_READ) begin
            rx_sr <= {rx_sr[6:0], sda_i};
        end
    end

    assign busy_o = (state != sfp_mgmt_pkg::I2C_IDLE);
    assign done_o = (state == sfp_mgmt_pkg::I2C_DONE);
    assign nack_o = nack_q;
    assign data_o = rx_sr;

endmodule

// ==== i2c_bus_arbiter.sv ====
// Round-robin arbiter that hands the I2C reader to one of two requesting peers
module i2c_bus_arbiter (
    input  logic                        clk_125mhz_int,
    input  logic                        arst_n_i,
    input  logic [1:0]                  req_i,
    input  sfp_mgmt_pkg::i2c_dev_addr_t dev_addr0_i,
    input  sfp_mgmt_pkg::i2c_reg_addr_t reg_addr0_i,
    input  sfp_mgmt_pkg::i2c_dev_addr_t dev_addr1_i,
    input  sfp_mgmt_pkg::i2c_reg_addr_t reg_addr1_i,
    input  logic                        busy_i,
    input  logic                        done_i,
    output logic                        start_o,
    output sfp_mgmt_pkg::i2c_dev_addr_t dev_addr_o,
    output sfp_mgmt_pkg::i2c_reg_addr_t reg_addr_o,
    output logic [1:0]                  done_o
);

    logic [1:0] grant_q;
    logic       last_q;
    logic       pick;

    // Peer not served last wins a tie
    assign pick = (req_i[0] && req_i[1]) ? !last_q : req_i[1];

    always_ff @(posedge clk_125mhz_int or negedge arst_n_i) begin
        if (!arst_n_i) begin
            grant_q <= '0;
            last_q  <= 1'b1;
            start_o <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (grant_q == 2'b00 && !busy_i && req_i != 2'b00) begin
                grant_q <= 2'b01 << pick;
                last_q  <= pick;
                start_o <= 1'b1;
            end else if (done_i) begin
                grant_q <= '0;
            end
        end
    end

    assign dev_addr_o = grant_q[1] ? dev_addr1_i : dev_addr0_i;
    assign reg_addr_o = grant_q[1] ? reg_addr1_i : reg_addr0_i;
    assign done_o     = grant_q & {2{done_i}};

endmodule

// ==== sfp_port_monitor.sv ====
// SFP presence and fault handling with TX disable, LEDs and the identifier read on insertion
module sfp_port_monitor (
    input  logic                        clk_125mhz_int,
    input  logic                        arst_n_i,
    input  logic                        tx_fault_i,
    input  logic                        rx_los_i,
    input  logic                        mod_abs_i,
    input  logic                        done_i,
    input  logic                        nack_i,
    input  sfp_mgmt_pkg::i2c_data_t     data_i,
    output logic                        req_o,
    output sfp_mgmt_pkg::i2c_dev_addr_t dev_addr_o,
    output sfp_mgmt_pkg::i2c_reg_addr_t reg_addr_o,
    output logic                        present_o,
    output sfp_mgmt_pkg::i2c_data_t     id_byte_o,
    output logic                        id_valid_o,
    output logic                        sfp_tx_disable_o,
    output logic [1:0]                  sfp_led_o
);

    sfp_mgmt_pkg::poll_state_t state;
    logic                      present_q;

    assign req_o      = (state == sfp_mgmt_pkg::POLL_REQ);
    assign dev_addr_o = sfp_map_pkg::SFP_ID_DEV_ADDR;
    assign reg_addr_o = sfp_map_pkg::SFP_ID_REG;
    assign present_o  = present_q;

    always_ff @(posedge clk_125mhz_int or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state            <= sfp_mgmt_pkg::POLL_IDLE;
            present_q        <= 1'b0;
            id_valid_o       <= 1'b0;
            sfp_tx_disable_o <= 1'b1;
            sfp_led_o        <= 2'b00;
        end else begin
            present_q        <= !mod_abs_i;
            sfp_tx_disable_o <= mod_abs_i || tx_fault_i;
            // LED 0 link light, LED 1 fault
            sfp_led_o        <= {tx_fault_i, !mod_abs_i && !rx_los_i};
            case (state)
                sfp_mgmt_pkg::POLL_IDLE: begin
                    if (present_q) begin
                        state <= sfp_mgmt_pkg::POLL_REQ;
                    end
                end
                sfp_mgmt_pkg::POLL_REQ: begin
                    if (done_i) begin
                        state      <= sfp_mgmt_pkg::POLL_WAIT;
                        id_valid_o <= !nack_i && present_q;
                    end
                end
                default: begin
                    // One read per insertion
                    if (!present_q) begin
                        state <= sfp_mgmt_pkg::POLL_IDLE;
                    end
                end
            endcase
            if (!present_q) begin
                id_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (state == sfp_mgmt_pkg::POLL_REQ && done_i && !nack_i) begin
            id_byte_o <= data_i;
        end
    end

endmodule

// ==== sfp_diag_poller.sv ====
// Periodic SFP temperature reader with a sticky error flag cleared on removal
module sfp_diag_poller #(
    parameter int POLL_PERIOD = 4000
) (
    input  logic                        clk_125mhz_int,
    input  logic                        arst_n_i,
    input  logic                        present_i,
    input  logic                        done_i,
    input  logic                        nack_i,
    input  sfp_mgmt_pkg::i2c_data_t     data_i,
    output logic                        req_o,
    output sfp_mgmt_pkg::i2c_dev_addr_t dev_addr_o,
    output sfp_mgmt_pkg::i2c_reg_addr_t reg_addr_o,
    output sfp_mgmt_pkg::i2c_data_t     temp_o,
    output logic                        temp_valid_o,
    output logic                        diag_err_o
);

    // Request is seen POLL_PERIOD cycles after the done pulse
    localparam logic [31:0] RELOAD = 32'(POLL_PERIOD - 2);

    sfp_mgmt_pkg::poll_state_t state;
    logic [31:0]               cnt_q;

    assign req_o      = (state == sfp_mgmt_pkg::POLL_REQ);
    assign dev_addr_o = sfp_map_pkg::SFP_DIAG_DEV_ADDR;
    assign reg_addr_o = sfp_map_pkg::SFP_TEMP_REG;

    always_ff @(posedge clk_125mhz_int or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state        <= sfp_mgmt_pkg::POLL_IDLE;
            cnt_q        <= '0;
            temp_valid_o <= 1'b0;
            diag_err_o   <= 1'b0;
        end else begin
            case (state)
                sfp_mgmt_pkg::POLL_IDLE: begin
                    if (present_i) begin
                        state <= sfp_mgmt_pkg::POLL_WAIT;
                        cnt_q <= RELOAD;
                    end
                end
                sfp_mgmt_pkg::POLL_WAIT: begin
                    if (!present_i) begin
                        state <= sfp_mgmt_pkg::POLL_IDLE;
                    end else if (cnt_q == '0) begin
                        state <= sfp_mgmt_pkg::POLL_REQ;
                    end else begin
                        cnt_q <= cnt_q - 32'd1;
                    end
                end
                default: begin
                    if (done_i) begin
                        state <= sfp_mgmt_pkg::POLL_WAIT;
                        cnt_q <= RELOAD;
                        if (nack_i) begin
                            diag_err_o   <= 1'b1;
                            temp_valid_o <= 1'b0;
                        end else begin
                            temp_valid_o <= present_i;
                        end
                    end
                end
            endcase
            if (!present_i) begin
                temp_valid_o <= 1'b0;
                diag_err_o   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (state == sfp_mgmt_pkg::POLL_REQ && done_i && !nack_i) begin
            temp_o <= data_i;
        end
    end

endmodule

// ==== sfp_mgmt_top.sv ====
// SFP management top level joining the synchronizer, I2C reader, arbiter and both peers
module sfp_mgmt_top #(
    parameter int SYNC_STAGES = 2,
    parameter int SCL_QUARTER = 4,
    parameter int POLL_PERIOD = 4000
) (
    input  logic                    clk_125mhz_int,
    input  logic                    arst_n_i,
    input  logic                    sfp_tx_fault_i,
    input  logic                    sfp_rx_los_i,
    input  logic                    sfp_mod_abs_i,
    inout  wire                     sfp_i2c_scl_io,
    inout  wire                     sfp_i2c_sda_io,
    output logic                    sfp_tx_disable_o,
    output logic [1:0]              sfp_led_o,
    output sfp_mgmt_pkg::i2c_data_t id_byte_o,
    output logic                    id_valid_o,
    output sfp_mgmt_pkg::i2c_data_t temp_o,
    output logic                    temp_valid_o,
    output logic                    diag_err_o
);

    logic tx_fault, rx_los, mod_abs, present;
    logic scl_in, sda_in, scl_drv, sda_drv, scl_oe, sda_oe;
    logic rd_start, rd_busy, rd_done, rd_nack;
    logic [1:0] req, done;
    sfp_mgmt_pkg::i2c_dev_addr_t rd_dev, mon_dev, diag_dev;
    sfp_mgmt_pkg::i2c_reg_addr_t rd_reg, mon_reg, diag_reg;
    sfp_mgmt_pkg::i2c_data_t     rd_data;

    // Open-drain pads, pulled up on the board
    assign sfp_i2c_scl_io = scl_oe ? 1'b0 : 1'bz;
    assign sfp_i2c_sda_io = sda_oe ? 1'b0 : 1'bz;

    board_io_sync #(.SYNC_STAGES(SYNC_STAGES))
    io_sync_inst (
        .clk_125mhz_int(clk_125mhz_int), .arst_n_i(arst_n_i),
        .sfp_tx_fault_i(sfp_tx_fault_i), .sfp_rx_los_i(sfp_rx_los_i),
        .sfp_mod_abs_i(sfp_mod_abs_i), .scl_pin_i(sfp_i2c_scl_io), .sda_pin_i(sfp_i2c_sda_io),
        .scl_drv_i(scl_drv), .sda_drv_i(sda_drv),
        .tx_fault_o(tx_fault), .rx_los_o(rx_los), .mod_abs_o(mod_abs),
        .scl_o(scl_in), .sda_o(sda_in), .scl_oe_o(scl_oe), .sda_oe_o(sda_oe)
    );

    i2c_random_reader #(.SCL_QUARTER(SCL_QUARTER))
    reader_inst (
        .clk_125mhz_int(clk_125mhz_int), .arst_n_i(arst_n_i),
        .start_i(rd_start), .dev_addr_i(rd_dev), .reg_addr_i(rd_reg),
        .scl_i(scl_in), .sda_i(sda_in), .scl_drv_o(scl_drv), .sda_drv_o(sda_drv),
        .busy_o(rd_busy), .done_o(rd_done), .nack_o(rd_nack), .data_o(rd_data)
    );

    // Peer 0 is the port monitor, peer 1 the temperature poller
    i2c_bus_arbiter
    arbiter_inst (
        .clk_125mhz_int(clk_125mhz_int), .arst_n_i(arst_n_i), .req_i(req),
        .dev_addr0_i(mon_dev), .reg_addr0_i(mon_reg),
        .dev_addr1_i(diag_dev), .reg_addr1_i(diag_reg),
        .busy_i(rd_busy), .done_i(rd_done), .start_o(rd_start),
        .dev_addr_o(rd_dev), .reg_addr_o(rd_reg), .done_o(done)
    );

    sfp_port_monitor
    monitor_inst (
        .clk_125mhz_int(clk_125mhz_int), .arst_n_i(arst_n_i),
        .tx_fault_i(tx_fault), .rx_los_i(rx_los), .mod_abs_i(mod_abs),
        .done_i(done[0]), .nack_i(rd_nack), .data_i(rd_data),
        .req_o(req[0]), .dev_addr_o(mon_dev), .reg_addr_o(mon_reg),
        .present_o(present), .id_byte_o(id_byte_o), .id_valid_o(id_valid_o),
        .sfp_tx_disable_o(sfp_tx_disable_o), .sfp_led_o(sfp_led_o)
    );

    sfp_diag_poller #(.POLL_PERIOD(POLL_PERIOD))
    poller_inst (
        .clk_125mhz_int(clk_125mhz_int), .arst_n_i(arst_n_i), .present_i(present),
        .done_i(done[1]), .nack_i(rd_nack), .data_i(rd_data),
        .req_o(req[1]), .dev_addr_o(diag_dev), .reg_addr_o(diag_reg),
        .temp_o(temp_o), .temp_valid_o(temp_valid_o), .diag_err_o(diag_err_o)
    );

endmodule

// ==== sfp_i2c_slave_model.sv ====
// Behavioral SFP two-wire slave for the testbench, answers the ID byte and temperature reads
module sfp_i2c_slave_model (
    input  logic       clk_125mhz_int,
    input  logic       arst_n_i,
    input  logic [7:0] id_value_i,
    input  logic [7:0] temp_value_i,
    input  logic       diag_nack_i,
    input  logic       scl_i,
    inout  wire        sda_io
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] M_IDLE = 2'd0;
    localparam logic [1:0] M_RX   = 2'd1;
    localparam logic [1:0] M_TX   = 2'd2;

    logic [1:0] mode;
    logic       scl_q;
    logic       sda_q;
    logic       sda_now;
    logic       sda_low;
    logic       in_ack;
    logic       rd_mode;
    logic       byte_cnt;
    logic [3:0] bit_cnt;
    logic [7:0] shift;
    logic [7:0] tx_byte;
    logic [6:0] dev_sel;
    logic [7:0] reg_ptr;
    logic       addr_ok;
    logic [7:0] next_byte;

    // Open drain, the pull-up lives in the testbench
    assign sda_io  = sda_low ? 1'b0 : 1'bz;
    assign sda_now = (sda_io !== 1'b0);

    // Diagnostics device can be told to ignore its address
    assign addr_ok = (shift[7:1] == sfp_map_pkg::SFP_ID_DEV_ADDR) ||
                     (shift[7:1] == sfp_map_pkg::SFP_DIAG_DEV_ADDR && !diag_nack_i);

    assign next_byte =
        (dev_sel == sfp_map_pkg::SFP_ID_DEV_ADDR && reg_ptr == sfp_map_pkg::SFP_ID_REG) ?
            id_value_i :
        (dev_sel == sfp_map_pkg::SFP_DIAG_DEV_ADDR && reg_ptr == sfp_map_pkg::SFP_TEMP_REG) ?
            temp_value_i : 8'hff;

    // Bus sampled on the system clock, edges found against the previous sample
    always_ff @(posedge clk_125mhz_int or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mode     <= M_IDLE;
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
            sda_low  <= 1'b0;
            in_ack   <= 1'b0;
            rd_mode  <= 1'b0;
            byte_cnt <= 1'b0;
            bit_cnt  <= '0;
            shift    <= '0;
            tx_byte  <= '0;
            dev_sel  <= '0;
            reg_ptr  <= '0;
        end else begin
            scl_q <= scl_i;
            sda_q <= sda_now;
            if (scl_q && scl_i && sda_q != sda_now) begin
                // SDA moving while SCL is high is START or STOP
                mode     <= sda_now ? M_IDLE : M_RX;
                sda_low  <= 1'b0;
                in_ack   <= 1'b0;
                byte_cnt <= 1'b0;
                bit_cnt  <= '0;
            end else if (!scl_q && scl_i) begin
                if (mode == M_RX && !in_ack && bit_cnt != 4'd8) begin
                    shift   <= {shift[6:0], sda_now};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (scl_q && !scl_i) begin
                if (in_ack) begin
                    in_ack <= 1'b0;
                    if (rd_mode) begin
                        mode    <= M_TX;
                        tx_byte <= next_byte;
                        sda_low <= !next_byte[7];
                        bit_cnt <= 4'd1;
                    end else begin
                        sda_low  <= 1'b0;
                        bit_cnt  <= '0;
                        byte_cnt <= 1'b1;
                    end
                end else if (mode == M_RX && bit_cnt == 4'd8) begin
                    if (!byte_cnt) begin
                        dev_sel <= shift[7:1];
                        rd_mode <= shift[0];
                        if (addr_ok) begin
                            sda_low <= 1'b1;
                            in_ack  <= 1'b1;
                        end else begin
                            mode <= M_IDLE;
                        end
                    end else begin
                        reg_ptr <= shift;
                        sda_low <= 1'b1;
                        in_ack  <= 1'b1;
                    end
                end else if (mode == M_TX) begin
                    if (bit_cnt != 4'd8) begin
                        sda_low <= !tx_byte[3'd7 - bit_cnt[2:0]];
                        bit_cnt <= bit_cnt + 4'd1;
                    end else begin
                        // Master NACKs the single byte
                        sda_low <= 1'b0;
                        mode    <= M_IDLE;
                    end
                end
            end
        end
    end

endmodule

// ==== sfp_mgmt_tb.sv ====
// Testbench for the SFP management block that runs the cage and I2C scenarios against a slave model
module sfp_mgmt_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SYNC_STAGES = 2;
    localparam int SCL_QUARTER = 4;
    localparam int POLL_PERIOD = 4000;
    // One random read is close to 40 SCL bit times of four quarters
    localparam int TXN_CYCLES  = 40 * 4 * (SCL_QUARTER + 2);
    localparam int WAIT_LIMIT  = POLL_PERIOD + 3 * TXN_CYCLES;
    localparam int NUM_POLLS   = 8;
    localparam int RUN_LIMIT   = NUM_POLLS * (POLL_PERIOD + TXN_CYCLES) + 2000;

    localparam int FLAG_ID_VALID   = 0;
    localparam int FLAG_TEMP_VALID = 1;
    localparam int FLAG_DIAG_ERR   = 2;

    logic                    clk_125mhz_int = 1'b0;
    logic                    arst_n;
    logic                    sfp_tx_fault;
    logic                    sfp_rx_los;
    logic                    sfp_mod_abs;
    wire                     scl_net;
    wire                     sda_net;
    logic                    sfp_tx_disable;
    logic [1:0]              sfp_led;
    sfp_mgmt_pkg::i2c_data_t id_byte;
    logic                    id_valid;
    sfp_mgmt_pkg::i2c_data_t temp;
    logic                    temp_valid;
    logic                    diag_err;
    sfp_mgmt_pkg::i2c_data_t id_value;
    sfp_mgmt_pkg::i2c_data_t temp_value;
    logic                    diag_nack;
    logic [2:0]              pin_hist [SYNC_STAGES+1];
    logic [2:0]              ref_ctrl;
    logic                    checks_on = 1'b0;
    int                      cycle_cnt = 0;

    pullup (scl_net);
    pullup (sda_net);

    sfp_mgmt_top #(
        .SYNC_STAGES(SYNC_STAGES),
        .SCL_QUARTER(SCL_QUARTER),
        .POLL_PERIOD(POLL_PERIOD)
    ) UUT (
        .clk_125mhz_int(clk_125mhz_int), .arst_n_i(arst_n),
        .sfp_tx_fault_i(sfp_tx_fault), .sfp_rx_los_i(sfp_rx_los), .sfp_mod_abs_i(sfp_mod_abs),
        .sfp_i2c_scl_io(scl_net), .sfp_i2c_sda_io(sda_net),
        .sfp_tx_disable_o(sfp_tx_disable), .sfp_led_o(sfp_led),
        .id_byte_o(id_byte), .id_valid_o(id_valid),
        .temp_o(temp), .temp_valid_o(temp_valid), .diag_err_o(diag_err)
    );

    sfp_i2c_slave_model sfp_model (
        .clk_125mhz_int(clk_125mhz_int), .arst_n_i(arst_n),
        .id_value_i(id_value), .temp_value_i(temp_value), .diag_nack_i(diag_nack),
        .scl_i(scl_net), .sda_io(sda_net)
    );

    always #4 clk_125mhz_int = ~clk_125mhz_int;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input sfp_mgmt_pkg::i2c_data_t got,
                              input sfp_mgmt_pkg::i2c_data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got 0x%01h, expected 0x%01h", name, got, exp));
        end
    endtask

    task automatic check_leds(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got 0x%01h, expected 0x%01h", name, got, exp));
        end
    endtask

    // Expected {tx_disable, led[1], led[0]} from {tx_fault, rx_los, mod_abs}
    function automatic logic [2:0] ctrl_ref(input logic [2:0] pins);
        logic tx_fault;
        logic rx_los;
        logic mod_abs;
        tx_fault = pins[2];
        rx_los   = pins[1];
        mod_abs  = pins[0];
        return {mod_abs || tx_fault, tx_fault, !mod_abs && !rx_los};
    endfunction

    function automatic logic flag_now(input int sel);
        case (sel)
            FLAG_ID_VALID:   return id_valid;
            FLAG_TEMP_VALID: return temp_valid;
            default:         return diag_err;
        endcase
    endfunction

    task automatic wait_for_flag(input int sel, input logic level, input string what);
        int n;
        n = 0;
        while (flag_now(sel) !== level) begin
            if (n == WAIT_LIMIT) begin
                report_failure($sformatf("%s did not happen within %0d cycles", what, WAIT_LIMIT));
            end
            @(negedge clk_125mhz_int);
            n++;
        end
    endtask

    task automatic wait_for_temp_change(input sfp_mgmt_pkg::i2c_data_t old_temp);
        int n;
        n = 0;
        while (temp === old_temp) begin
            if (n == WAIT_LIMIT) begin
                report_failure($sformatf("temp_o kept its old value for %0d cycles", WAIT_LIMIT));
            end
            @(negedge clk_125mhz_int);
            n++;
        end
    endtask

    // Cage pins delayed like the synchronizer and reset to its idle view
    always @(posedge clk_125mhz_int or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i <= SYNC_STAGES; i++) begin
                pin_hist[i] <= 3'b011;
            end
        end else begin
            pin_hist[0] <= {sfp_tx_fault, sfp_rx_los, sfp_mod_abs};
            for (int i = 1; i <= SYNC_STAGES; i++) begin
                pin_hist[i] <= pin_hist[i-1];
            end
        end
    end

    always @(posedge clk_125mhz_int) begin
        checks_on <= arst_n;
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == RUN_LIMIT) begin
            report_failure($sformatf("run did not finish within %0d cycles", RUN_LIMIT));
        end
    end

    // Control outputs lag the pins by SYNC_STAGES+1 clocks
    always @(negedge clk_125mhz_int) begin
        if (checks_on) begin
            ref_ctrl = ctrl_ref(pin_hist[SYNC_STAGES]);
            check_bit("sfp_tx_disable_o", sfp_tx_disable, ref_ctrl[2]);
            check_leds("sfp_led_o", sfp_led, ref_ctrl[1:0]);
        end
    end

    initial begin
        sfp_mgmt_pkg::i2c_data_t old_temp;
        logic [2:0]              exp_ctrl;
        void'($urandom(24210));
        arst_n       = 1'b0;
        sfp_tx_fault = 1'b0;
        sfp_rx_los   = 1'b1;
        sfp_mod_abs  = 1'b1;
        diag_nack    = 1'b0;
        id_value     = 8'($urandom);
        temp_value   = 8'($urandom);
        repeat (3) @(negedge clk_125mhz_int);
        arst_n = 1'b1;

        // Empty cage after reset
        repeat (SYNC_STAGES + 4) @(negedge clk_125mhz_int);
        check_bit("sfp_tx_disable_o", sfp_tx_disable, 1'b1);
        check_leds("sfp_led_o", sfp_led, 2'b00);
        check_bit("id_valid_o", id_valid, 1'b0);
        check_bit("temp_valid_o", temp_valid, 1'b0);

        // Insertion triggers the ID read
        sfp_mod_abs = 1'b0;
        sfp_rx_los  = 1'b0;
        wait_for_flag(FLAG_ID_VALID, 1'b1, "id_valid_o rise after insertion");
        check_data("id_byte_o", id_byte, id_value);

        // First poll and then a new value from the module
        wait_for_flag(FLAG_TEMP_VALID, 1'b1, "temp_valid_o rise after insertion");
        check_data("temp_o", temp, temp_value);
        old_temp = temp_value;
        while (temp_value == old_temp) begin
            temp_value = 8'($urandom);
        end
        wait_for_temp_change(old_temp);
        check_data("temp_o", temp, temp_value);
        check_bit("temp_valid_o", temp_valid, 1'b1);

        // Fault and loss of signal combinations
        for (int combo = 0; combo < 4; combo++) begin
            sfp_tx_fault = combo[1];
            sfp_rx_los   = combo[0];
            repeat (SYNC_STAGES + 3) @(negedge clk_125mhz_int);
            exp_ctrl = ctrl_ref({sfp_tx_fault, sfp_rx_los, sfp_mod_abs});
            check_bit("sfp_tx_disable_o", sfp_tx_disable, exp_ctrl[2]);
            check_leds("sfp_led_o", sfp_led, exp_ctrl[1:0]);
        end
        sfp_tx_fault = 1'b0;
        sfp_rx_los   = 1'b0;

        // Diagnostics device stops answering
        diag_nack = 1'b1;
        wait_for_flag(FLAG_DIAG_ERR, 1'b1, "diag_err_o rise on missing acknowledge");
        check_bit("temp_valid_o", temp_valid, 1'b0);
        check_bit("id_valid_o", id_valid, 1'b1);
        check_data("id_byte_o", id_byte, id_value);
        // Error stays set through the next good poll
        diag_nack = 1'b0;
        wait_for_flag(FLAG_TEMP_VALID, 1'b1, "temp_valid_o rise after the device answers again");
        check_bit("diag_err_o", diag_err, 1'b1);
        check_data("temp_o", temp, temp_value);
        check_data("id_byte_o", id_byte, id_value);

        // Removal
        sfp_mod_abs = 1'b1;
        wait_for_flag(FLAG_ID_VALID, 1'b0, "id_valid_o clear on removal");
        wait_for_flag(FLAG_DIAG_ERR, 1'b0, "diag_err_o clear on removal");
        check_bit("sfp_tx_disable_o", sfp_tx_disable, 1'b1);
        check_leds("sfp_led_o", sfp_led, 2'b00);
        check_bit("temp_valid_o", temp_valid, 1'b0);
        repeat (10) @(negedge clk_125mhz_int);
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== vlog.f ====
sfp_mgmt_pkg.sv
sfp_map_pkg.sv
board_io_sync.sv
i2c_random_reader.sv
i2c_bus_arbiter.sv
sfp_port_monitor.sv
sfp_diag_poller.sv
sfp_mgmt_top.sv
sfp_i2c_slave_model.sv
sfp_mgmt_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the SFP management testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module sfp_mgmt_tb \
    -o sfp_mgmt_sim && ./obj_dir/sfp_mgmt_sim; } > sim.log 2>&1 \
    || echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
